// File: riscv_pkg.sv
`default_nettype none

package riscv_pkg;

    // ------------------------------------------------
    // widths and sizes
    // ------------------------------------------------
    localparam int unsigned XLEN = 32;
    localparam logic [XLEN-1:0] RESET_VECTOR = 32'h0000_0100;

    localparam int unsigned FIFO_DEPTH_X = 2; // depth >= read latency + 2
    localparam logic [FIFO_DEPTH_X:0] FIFO_DEPTH = {1'b1, {FIFO_DEPTH_X{1'b0}}};

    localparam int unsigned IMEM_WORDS_X = 8; // 256 words, 1 KiB
    localparam int unsigned IMEM_WORDS = 1 << IMEM_WORDS_X;

    // ------------------------------------------------
    // start-of-fetch id
    // ------------------------------------------------
    typedef enum logic [0:0] {
        SOFID_RUN  = 1'b0, // sequential fetch
        SOFID_JUMP = 1'b1  // first fetch after vectoring
    } sofid_t;

    // queue entry seen by the decoder
    typedef struct packed {
        sofid_t          sofid;
        logic            ferr;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] ins;
    } fetch_entry_t;

    typedef struct packed {
        logic            rerr; // address beyond the ram
        logic [XLEN-1:0] data;
    } imem_rsp_t;

    typedef struct packed {
        logic [IMEM_WORDS_X-1:0] addr; // word index
        logic [XLEN-1:0]         data;
    } imem_load_t;

endpackage

`default_nettype wire

// File: fetch_queue.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_queue (
    input  wire                          clk_i,
    input  wire                          clk_en_i,
    input  wire                          resetb_i,
    // write side, bus responses
    input  wire                          wr_i,
    input  wire riscv_pkg::fetch_entry_t din_i,
    // read side, decoder
    input  wire                          rd_i,
    output riscv_pkg::fetch_entry_t      dout_o,
    output logic                         empty_o,
    output logic                         full_o
);

    import riscv_pkg::*;

    fetch_entry_t            mem_q [0:FIFO_DEPTH-1];
    logic [FIFO_DEPTH_X-1:0] wr_ptr_q;
    logic [FIFO_DEPTH_X-1:0] rd_ptr_q;
    logic [FIFO_DEPTH_X:0]   count_q;
    logic                    push;
    logic                    pop;

    assign push = clk_en_i & wr_i;
    assign pop  = clk_en_i & rd_i;

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == FIFO_DEPTH);
    assign dout_o  = mem_q[rd_ptr_q]; // head is visible without latency

    // ------------------------------------------------
    // pointers and level
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1; // wraps, depth is a power of 2
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= din_i;
        end
    end

    assert property (@(posedge clk_i) disable iff (!resetb_i)
        clk_en_i && wr_i && full_o |-> rd_i)
        else $error("fetch_queue: write into a full queue");

    assert property (@(posedge clk_i) disable iff (!resetb_i)
        clk_en_i && rd_i |-> !empty_o)
        else $error("fetch_queue: read from an empty queue");

endmodule

`default_nettype wire

// File: imem.sv
`timescale 1ns/1ps
`default_nettype none

module imem (
    input  wire                         clk_i,
    input  wire                         clk_en_i,
    input  wire                         resetb_i,
    // fetch request
    input  wire                         ireq_valid_i,
    input  wire [riscv_pkg::XLEN-1:0]   ireq_addr_i,
    output logic                        ireq_ready_o,
    // fetch response, one cycle after accept
    output logic                        irsp_valid_o,
    output riscv_pkg::imem_rsp_t        irsp_o,
    // load port
    input  wire                         load_valid_i,
    input  wire riscv_pkg::imem_load_t  load_i
);

    import riscv_pkg::*;

    logic [XLEN-1:0]         mem_q [0:IMEM_WORDS-1];
    logic                    accept;
    logic                    in_range;
    logic [IMEM_WORDS_X-1:0] word_idx;

    // ------------------------------------------------
    // arbitration and decode
    // ------------------------------------------------
    assign ireq_ready_o = ~load_valid_i; // loads always win
    assign accept       = ireq_valid_i & ireq_ready_o;
    assign word_idx     = ireq_addr_i[IMEM_WORDS_X+1:2];
    assign in_range     = (ireq_addr_i[XLEN-1:IMEM_WORDS_X+2] == '0);

    // load port write
    always_ff @(posedge clk_i) begin
        if (clk_en_i && load_valid_i) begin
            mem_q[load_i.addr] <= load_i.data;
        end
    end

    // ------------------------------------------------
    // read response
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            irsp_valid_o <= 1'b0;
        end else if (clk_en_i) begin
            irsp_valid_o <= accept; // exactly one response per accept
        end
    end

    always_ff @(posedge clk_i) begin
        if (clk_en_i && accept) begin
            irsp_o.rerr <= ~in_range;
            irsp_o.data <= in_range ? mem_q[word_idx] : '0; // zero on error
        end
    end

    assert property (@(posedge clk_i) disable iff (!resetb_i)
        clk_en_i && accept |-> ireq_addr_i[1:0] == 2'b00)
        else $error("imem: unaligned fetch address");

endmodule

`default_nettype wire

// File: pfu.sv
`timescale 1ns/1ps
`default_nettype none

module pfu (
    input  wire                         clk_i,
    input  wire                         clk_en_i,
    input  wire                         resetb_i,
    // instruction memory request
    input  wire                         ireq_ready_i,
    output logic                        ireq_valid_o,
    output logic [1:0]                  ireq_hpl_o,
    output logic [riscv_pkg::XLEN-1:0]  ireq_addr_o,
    // instruction memory response
    output logic                        irsp_ready_o,
    input  wire                         irsp_valid_i,
    input  wire riscv_pkg::imem_rsp_t   irsp_i,
    // decoder
    output logic                        ids_dav_o,
    input  wire                         ids_ack_i,
    output riscv_pkg::fetch_entry_t     ids_entry_o,
    // vectoring controller
    output logic                        hvec_pc_ready_o,
    input  wire                         hvec_pc_wr_i,
    input  wire [riscv_pkg::XLEN-1:0]   hvec_pc_i,
    // execute stage
    input  wire [1:0]                   exs_hpl_i
);

    import riscv_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE     = 2'b00,
        ST_REQ_WAIT = 2'b01,
        ST_RSP_WAIT = 2'b10
    } state_t;

    state_t                state_q;
    state_t                state_d;
    logic                  issue;        // a new request goes on the bus
    logic                  req_accepted;
    logic                  has_credit;
    logic [FIFO_DEPTH_X:0] credits_q;
    logic [XLEN-1:0]       pc_q;         // address of the next new request
    logic                  jump_pending_q;
    sofid_t                issue_sofid;
    logic [XLEN-1:0]       hold_addr_q;  // request stalled by the memory
    sofid_t                hold_sofid_q;
    sofid_t                bus_sofid;
    logic [XLEN-1:0]       req_pc_q;     // paired with the response
    sofid_t                req_sofid_q;
    fetch_entry_t          fifo_din;
    logic                  fifo_empty;

    assign ireq_hpl_o   = exs_hpl_i;
    assign irsp_ready_o = 1'b1; // credits guarantee room in the queue
    assign ids_dav_o    = ~fifo_empty;
    assign has_credit   = |credits_q;
    assign issue_sofid  = jump_pending_q ? SOFID_JUMP : SOFID_RUN;

    // a waiting request keeps its address even if the pc is vectored
    always_comb begin
        if (state_q == ST_REQ_WAIT) begin
            ireq_addr_o = hold_addr_q;
            bus_sofid   = hold_sofid_q;
        end else begin
            ireq_addr_o = pc_q;
            bus_sofid   = issue_sofid;
        end
    end

    // ------------------------------------------------
    // bus fsm
    // ------------------------------------------------
    always_comb begin
        ireq_valid_o    = 1'b0;
        hvec_pc_ready_o = 1'b0;
        issue           = 1'b0;
        req_accepted    = 1'b0;
        state_d         = state_q;
        case (state_q)
            ST_IDLE: begin
                if (has_credit) begin
                    ireq_valid_o = 1'b1;
                    issue        = 1'b1;
                    if (ireq_ready_i) begin
                        req_accepted = 1'b1;
                        state_d      = ST_RSP_WAIT;
                    end else begin
                        state_d = ST_REQ_WAIT;
                    end
                end
            end
            ST_REQ_WAIT: begin
                ireq_valid_o = 1'b1;
                if (ireq_ready_i) begin
                    req_accepted = 1'b1;
                    state_d      = ST_RSP_WAIT;
                end
            end
            ST_RSP_WAIT: begin
                if (irsp_valid_i) begin
                    if (has_credit) begin
                        hvec_pc_ready_o = 1'b1; // request boundary
                        ireq_valid_o    = 1'b1;
                        issue           = 1'b1;
                        if (ireq_ready_i) begin
                            req_accepted = 1'b1;
                        end else begin
                            state_d = ST_REQ_WAIT;
                        end
                    end else begin
                        state_d = ST_IDLE;
                    end
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            state_q <= ST_IDLE;
        end else if (clk_en_i) begin
            state_q <= state_d;
        end
    end

    // free queue slots not yet claimed by a request
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            credits_q <= FIFO_DEPTH;
        end else if (clk_en_i) begin
            if (req_accepted && !ids_ack_i) begin
                credits_q <= credits_q - 1'b1;
            end else if (!req_accepted && ids_ack_i) begin
                credits_q <= credits_q + 1'b1;
            end
        end
    end

    // ------------------------------------------------
    // pc and jump tagging
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            pc_q           <= RESET_VECTOR;
            jump_pending_q <= 1'b0;
        end else if (clk_en_i) begin
            if (hvec_pc_wr_i) begin
                pc_q           <= hvec_pc_i; // vector wins over increment
                jump_pending_q <= 1'b1;
            end else if (issue) begin
                pc_q           <= pc_q + 32'd4;
                jump_pending_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (clk_en_i && issue && !ireq_ready_i) begin
            hold_addr_q  <= pc_q;
            hold_sofid_q <= issue_sofid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (clk_en_i && req_accepted) begin
            req_pc_q    <= ireq_addr_o;
            req_sofid_q <= bus_sofid;
        end
    end

    // ------------------------------------------------
    // queue
    // ------------------------------------------------
    always_comb begin
        fifo_din.sofid = req_sofid_q;
        fifo_din.ferr  = irsp_i.rerr;
        fifo_din.pc    = req_pc_q;
        fifo_din.ins   = irsp_i.data;
    end

    fetch_queue fetch_queue_inst (
        .clk_i    (clk_i),
        .clk_en_i (clk_en_i),
        .resetb_i (resetb_i),
        .wr_i     (irsp_valid_i),
        .din_i    (fifo_din),
        .rd_i     (ids_ack_i),
        .dout_o   (ids_entry_o),
        .empty_o  (fifo_empty),
        .full_o   ()
    );

    assert property (@(posedge clk_i) disable iff (!resetb_i)
        state_q == ST_REQ_WAIT |-> !irsp_valid_i)
        else $error("pfu: response while a request is still waiting");

    assert property (@(posedge clk_i) disable iff (!resetb_i)
        credits_q <= FIFO_DEPTH)
        else $error("pfu: credit count above queue depth");

endmodule

`default_nettype wire

// File: fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
    input  wire                         clk_i,
    input  wire                         clk_en_i,
    input  wire                         resetb_i,
    // decoder
    output logic                        ids_dav_o,
    input  wire                         ids_ack_i,
    output riscv_pkg::fetch_entry_t     ids_entry_o,
    // vectoring controller
    output logic                        hvec_pc_ready_o,
    input  wire                         hvec_pc_wr_i,
    input  wire [riscv_pkg::XLEN-1:0]   hvec_pc_i,
    input  wire [1:0]                   exs_hpl_i,
    // ram load port
    input  wire                         load_valid_i,
    input  wire riscv_pkg::imem_load_t  load_i
);

    import riscv_pkg::*;

    // ------------------------------------------------
    // pfu to imem
    // ------------------------------------------------
    logic            ireq_valid;
    logic            ireq_ready;
    logic [XLEN-1:0] ireq_addr;
    logic            irsp_valid;
    imem_rsp_t       irsp;

    pfu pfu_inst (
        .clk_i           (clk_i),
        .clk_en_i        (clk_en_i),
        .resetb_i        (resetb_i),
        .ireq_ready_i    (ireq_ready),
        .ireq_valid_o    (ireq_valid),
        .ireq_hpl_o      (),
        .ireq_addr_o     (ireq_addr),
        .irsp_ready_o    (),
        .irsp_valid_i    (irsp_valid),
        .irsp_i          (irsp),
        .ids_dav_o       (ids_dav_o),
        .ids_ack_i       (ids_ack_i),
        .ids_entry_o     (ids_entry_o),
        .hvec_pc_ready_o (hvec_pc_ready_o),
        .hvec_pc_wr_i    (hvec_pc_wr_i),
        .hvec_pc_i       (hvec_pc_i),
        .exs_hpl_i       (exs_hpl_i)
    );

    imem imem_inst (
        .clk_i        (clk_i),
        .clk_en_i     (clk_en_i),
        .resetb_i     (resetb_i),
        .ireq_valid_i (ireq_valid),
        .ireq_addr_i  (ireq_addr),
        .ireq_ready_o (ireq_ready),
        .irsp_valid_o (irsp_valid),
        .irsp_o       (irsp),
        .load_valid_i (load_valid_i),
        .load_i       (load_i)
    );

endmodule

`default_nettype wire

// File: tb_fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top;

    import riscv_pkg::*;

    logic            clk_i;
    logic            clk_en_i;
    logic            resetb_i;
    logic            ids_dav_o;
    logic            ids_ack_i;
    fetch_entry_t    ids_entry_o;
    logic            hvec_pc_ready_o;
    logic            hvec_pc_wr_i;
    logic [XLEN-1:0] hvec_pc_i;
    logic [1:0]      exs_hpl_i;
    logic            load_valid_i;
    imem_load_t      load_i;

    logic [XLEN-1:0] model_mem [0:IMEM_WORDS-1];
    logic            rewritten [0:IMEM_WORDS-1]; // loaded while fetching
    logic [XLEN-1:0] exp_pc;                     // expected next pc
    logic [XLEN-1:0] vec_targets [$];            // written, jump not seen yet
    logic [31:0]     rng_state;
    logic            prev_en;
    logic            held_dav;
    fetch_entry_t    held_entry;
    int              n_entries;
    int              n_jumps;

    fetch_top fetch_top_inst (
        .clk_i           (clk_i),
        .clk_en_i        (clk_en_i),
        .resetb_i        (resetb_i),
        .ids_dav_o       (ids_dav_o),
        .ids_ack_i       (ids_ack_i),
        .ids_entry_o     (ids_entry_o),
        .hvec_pc_ready_o (hvec_pc_ready_o),
        .hvec_pc_wr_i    (hvec_pc_wr_i),
        .hvec_pc_i       (hvec_pc_i),
        .exs_hpl_i       (exs_hpl_i),
        .load_valid_i    (load_valid_i),
        .load_i          (load_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic chance(input int pct);
        return (next_rand() % 100) < pct;
    endfunction

    // --------------------------------------------------
    // error reporting and compare tasks
    // --------------------------------------------------
    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("ERR t=%0t %s expected=%h actual=%h", $time, name, exp, act);
        $display("Test failures found");
        $fatal(1, "value mismatch on %s", name);
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "%s", what);
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_mismatch(name, {31'b0, exp}, {31'b0, act});
        end
    endtask

    task automatic check_entry(input fetch_entry_t exp, input fetch_entry_t act);
        if (act.sofid !== exp.sofid) begin
            report_mismatch("ids_entry_o.sofid", {31'b0, exp.sofid}, {31'b0, act.sofid});
        end
        if (act.ferr !== exp.ferr) begin
            report_mismatch("ids_entry_o.ferr", {31'b0, exp.ferr}, {31'b0, act.ferr});
        end
        if (act.pc !== exp.pc) begin
            report_mismatch("ids_entry_o.pc", exp.pc, act.pc);
        end
        if (act.ins !== exp.ins) begin
            report_mismatch("ids_entry_o.ins", exp.ins, act.ins);
        end
    endtask

    // --------------------------------------------------
    // expected stream
    // --------------------------------------------------
    task automatic take_entry(input fetch_entry_t act);
        fetch_entry_t exp;
        int           hit;
        hit = -1;
        if (act.sofid == SOFID_JUMP) begin
            n_jumps++;
            foreach (vec_targets[i]) begin
                if (hit < 0 && vec_targets[i] == act.pc) begin
                    hit = i;
                end
            end
        end
        if (hit >= 0) begin
            exp_pc = vec_targets[hit];
            repeat (hit + 1) begin
                vec_targets.delete(0); // older writes merged or already jumped
            end
        end
        exp.sofid = (hit >= 0) ? SOFID_JUMP : SOFID_RUN;
        exp.pc    = exp_pc;
        exp.ferr  = (exp_pc >= IMEM_WORDS * 4);
        exp.ins   = exp.ferr ? '0 : model_mem[exp_pc[IMEM_WORDS_X+1:2]];
        if (!exp.ferr && rewritten[exp_pc[IMEM_WORDS_X+1:2]]) begin
            exp.ins = act.ins; // word changed under the fetch, old or new
        end
        check_entry(exp, act);
        exp_pc = exp_pc + 32'd4;
        n_entries++;
    endtask

    // one clock, inputs driven 1 ns after the edge
    task automatic step(input logic en, input logic ack, input logic vec_wr,
                        input logic [XLEN-1:0] vec_pc, input logic ld);
        logic [31:0] rnd;
        @(posedge clk_i);
        #1;
        if (!prev_en) begin // edge was gated, outputs must hold
            check_flag("ids_dav_o", held_dav, ids_dav_o);
            if (held_dav) begin
                check_entry(held_entry, ids_entry_o);
            end
        end
        held_dav     = ids_dav_o;
        held_entry   = ids_entry_o;
        prev_en      = en;
        rnd          = next_rand();
        clk_en_i     = en;
        ids_ack_i    = en & ack & ids_dav_o;
        hvec_pc_wr_i = en & vec_wr;
        hvec_pc_i    = vec_pc;
        exs_hpl_i    = rnd[1:0];
        load_valid_i = en & ld;
        if (ids_ack_i) begin
            take_entry(ids_entry_o);
        end
        if (hvec_pc_wr_i) begin
            vec_targets.push_back(vec_pc);
        end
        if (load_valid_i) begin
            load_i.addr = rnd[IMEM_WORDS_X+1:2];
            load_i.data = next_rand();
            model_mem[load_i.addr] = load_i.data;
            rewritten[load_i.addr] = 1'b1;
        end
    endtask

    task automatic random_traffic(input int cycles, input int ack_pct, input int en_pct,
                                  input int vec_pct, input int ld_pct);
        logic [XLEN-1:0] target;
        repeat (cycles) begin
            target = next_rand() & 32'h0000_03fc; // aligned, inside the ram
            step(chance(en_pct), chance(ack_pct), chance(vec_pct), target, chance(ld_pct));
        end
    endtask

    task automatic wait_jump_seen(input int limit);
        int n;
        n = 0;
        while (vec_targets.size() != 0 && n < limit) begin
            step(1'b1, 1'b1, 1'b0, '0, 1'b0);
            n++;
        end
        if (vec_targets.size() != 0) begin
            report_failure("timeout: no JUMP entry came for the last vector write");
        end
    endtask

    task automatic wait_pc_reached(input logic [XLEN-1:0] pc, input int limit);
        int n;
        n = 0;
        while (exp_pc < pc && n < limit) begin
            step(chance(80), 1'b1, 1'b0, '0, 1'b0);
            n++;
        end
        if (exp_pc < pc) begin
            report_failure($sformatf("timeout: fetch stream never reached pc %h", pc));
        end
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        int jumps_before;
        rng_state    = 32'd83;
        n_entries    = 0;
        n_jumps      = 0;
        prev_en      = 1'b1;
        held_dav     = 1'b0;
        held_entry   = '0;
        exp_pc       = RESET_VECTOR;
        clk_en_i     = 1'b1;
        resetb_i     = 1'b0;
        ids_ack_i    = 1'b0;
        hvec_pc_wr_i = 1'b0;
        hvec_pc_i    = '0;
        exs_hpl_i    = 2'b00;
        load_valid_i = 1'b0;
        load_i       = '0;
        for (int w = 0; w < IMEM_WORDS; w++) begin
            rewritten[w] = 1'b0;
        end

        repeat (8) begin
            @(posedge clk_i);
            #1;
            check_flag("ids_dav_o", 1'b0, ids_dav_o);
            check_flag("hvec_pc_ready_o", 1'b0, hvec_pc_ready_o);
        end
        resetb_i = 1'b1;

        // preload, first fetch waits behind the load port
        for (int w = 0; w < IMEM_WORDS; w++) begin
            load_valid_i   = 1'b1;
            load_i.addr    = IMEM_WORDS_X'(w);
            load_i.data    = next_rand();
            model_mem[w]   = load_i.data;
            @(posedge clk_i);
            #1;
            check_flag("ids_dav_o", 1'b0, ids_dav_o);
            check_flag("hvec_pc_ready_o", 1'b0, hvec_pc_ready_o);
        end
        load_valid_i = 1'b0;

        random_traffic(400, 60, 100, 0, 0);  // plain sequential stream
        random_traffic(400, 60, 75, 0, 3);   // loads and enable gaps
        random_traffic(60, 0, 100, 0, 0);    // long decoder stall
        random_traffic(200, 90, 100, 0, 0);
        random_traffic(1500, 70, 85, 4, 2);  // vectoring
        wait_jump_seen(200);

        // stall until credits run out, no request between the writes
        random_traffic(20, 0, 100, 0, 0);
        jumps_before = n_jumps;

        // burst of writes, latest target must win
        step(1'b1, 1'b0, 1'b1, 32'h0000_0040, 1'b0);
        step(1'b1, 1'b0, 1'b1, 32'h0000_0080, 1'b0);
        step(1'b1, 1'b0, 1'b1, 32'h0000_00c0, 1'b0);
        wait_jump_seen(200);
        if (n_jumps - jumps_before != 1) begin
            report_mismatch("JUMP entries per write burst", 32'd1, n_jumps - jumps_before);
        end

        // run off the end of the ram
        step(1'b1, 1'b1, 1'b1, 32'h0000_03f0, 1'b0);
        wait_jump_seen(200);
        wait_pc_reached(32'h0000_0440, 400);

        $display("entries checked: %0d", n_entries);
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
riscv_pkg.sv
fetch_queue.sv
imem.sv
pfu.sv
fetch_top.sv
tb_fetch_top.sv

// File: Bender.yml
package:
  name: fetch_top

sources:
  - riscv_pkg.sv
  - fetch_queue.sv
  - imem.sv
  - pfu.sv
  - fetch_top.sv
  - target: test
    files:
      - tb_fetch_top.sv
